// ==== common/len5_pkg.sv ====
package len5_pkg;

  // ------------------------------
  // ISA widths
  // ------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned REG_IDX_LEN = 5;

  // Exception causes carried with each result
  typedef enum logic [3:0] {
    E_NONE          = 4'h0,
    E_ILLEGAL       = 4'h2,
    E_BREAKPOINT    = 4'h3,
    E_LD_FAULT      = 4'h5,
    E_ST_FAULT      = 4'h7,
    E_ECALL         = 4'hb,
    // Branch unit reports a wrong-path redirect here
    E_MISPREDICTION = 4'hf
  } except_code_t;

endpackage

// ==== common/expipe_pkg.sv ====
package expipe_pkg;
  import len5_pkg::*;

  // ------------------------------
  // Reorder buffer geometry
  // ------------------------------
  localparam int unsigned ROB_DEPTH   = 4;
  localparam int unsigned ROB_IDX_LEN = $clog2(ROB_DEPTH);

  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // One ROB entry, filled at issue and completed from the CDB
  typedef struct packed {
    logic [REG_IDX_LEN-1:0] rd_idx;
    // Writes rd on retirement
    logic                   rd_upd;
    // Never commits through the lookahead slot
    logic                   order_crit;
    // May still redirect flow, younger stores wait on it
    logic                   mem_crit;
    logic                   res_ready;
    logic [XLEN-1:0]        res_value;
    logic                   except_raised;
    except_code_t           except_code;
    // All older entries are safe for memory access
    logic                   mem_clear;
  } rob_entry_t;

  // Result broadcast by an execution unit
  typedef struct packed {
    rob_idx_t        rob_idx;
    logic [XLEN-1:0] res_value;
    logic            except_raised;
    except_code_t    except_code;
  } cdb_data_t;

endpackage

// ==== common/rob_ifs.sv ====
`timescale 1ns/1ps

// Result bus into the ROB
interface cdb_if import expipe_pkg::*; ();
  logic      valid;
  logic      ready;
  cdb_data_t data;

  modport rob (input valid, input data, output ready);
  modport src (output valid, output data, input ready);
endinterface

// Combinational lookup of ROB results for issuing operands
interface opfwd_if import len5_pkg::*, expipe_pkg::*; ();
  rob_idx_t        rs1_idx;
  rob_idx_t        rs2_idx;
  logic            rs1_valid;
  logic            rs1_ready;
  logic [XLEN-1:0] rs1_value;
  logic            rs2_valid;
  logic            rs2_ready;
  logic [XLEN-1:0] rs2_value;

  modport rob (
    input  rs1_idx, rs2_idx,
    output rs1_valid, rs1_ready, rs1_value, rs2_valid, rs2_ready, rs2_value
  );
  modport rs (
    output rs1_idx, rs2_idx,
    input  rs1_valid, rs1_ready, rs1_value, rs2_valid, rs2_ready, rs2_value
  );
endinterface

// Commit handshake, entry leaves on valid and ready
interface rob_commit_if import expipe_pkg::*; ();
  logic       valid;
  logic       ready;
  rob_entry_t data;
  // Slot being retired, used to release the register status
  rob_idx_t   idx;

  modport rob (output valid, output data, output idx, input ready);
  modport cu (input valid, input data, input idx, output ready);
endinterface

// ==== src/modn_counter.sv ====
`timescale 1ns/1ps

module modn_counter #(
  parameter int unsigned N    = 4,
  parameter int unsigned INIT = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 en_i,
  input  logic                 clr_i,
  output logic [$clog2(N)-1:0] count_o
);

  // Clear wins over a pending increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_o <= INIT[$clog2(N)-1:0];
    end else if (clr_i) begin
      count_o <= INIT[$clog2(N)-1:0];
    end else if (en_i) begin
      // Explicit wrap, N need not be a power of two
      if (count_o == ($clog2(N))'(N - 1)) begin
        count_o <= '0;
      end else begin
        count_o <= count_o + 1'b1;
      end
    end
  end

  // Clear lands on the start value one cycle later
  a_clr_init: assert property (
    @(posedge clk_i) disable iff (!rst_ni) clr_i |=> count_o == INIT[$clog2(N)-1:0]
  );

endmodule

// ==== rob/rob.sv ====
`timescale 1ns/1ps

module rob import len5_pkg::*, expipe_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  // Issue stage
  input  logic       issue_valid_i,
  output logic       issue_ready_o,
  input  rob_entry_t issue_data_i,
  output rob_idx_t   issue_tail_idx_o,
  // Result bus and operand lookup
  cdb_if.rob         cdb,
  opfwd_if.rob       opfwd,
  // Store unit
  input  rob_idx_t   sb_mem_idx_i,
  output logic       sb_mem_clear_o,
  // Commit stage
  rob_commit_if.rob  comm
);

  // Entry storage
  logic [ROB_DEPTH-1:0] valid_q;
  rob_entry_t           data_q [ROB_DEPTH];

  // Pointers
  rob_idx_t head_idx;
  rob_idx_t tail_idx;
  rob_idx_t clear_idx;
  rob_idx_t work_idx;
  rob_idx_t commit_idx;

  logic fifo_push, fifo_pop, rob_full;
  logic entry_clear, cdb_clear, clear_adv;
  logic head_waw, comm_in_order, comm_ooo, commit_valid;

  // ------------------------------
  // Control
  // ------------------------------
  // Occupied tail slot means no free entry
  assign rob_full      = valid_q[tail_idx];
  assign issue_ready_o = ~rob_full & ~flush_i;
  assign fifo_push     = issue_valid_i & issue_ready_o;
  assign fifo_pop      = commit_valid & comm.ready;

  // Clear pointer waits on the oldest entry that may still redirect flow
  assign entry_clear = data_q[clear_idx].res_ready & ~data_q[clear_idx].except_raised &
                       (data_q[clear_idx].except_code != E_MISPREDICTION);
  // Result arriving this cycle counts as well
  assign cdb_clear   = cdb.valid & (cdb.data.rob_idx == clear_idx) &
                       ~cdb.data.except_raised &
                       (cdb.data.except_code != E_MISPREDICTION);
  // Already marked entry means the pointer went all the way round
  assign clear_adv   = valid_q[clear_idx] & ~data_q[clear_idx].mem_clear &
                       (~data_q[clear_idx].mem_crit | entry_clear | cdb_clear);

  // In-order slot
  assign comm_in_order = valid_q[head_idx] & data_q[head_idx].res_ready;

  // Lookahead must not overtake a write to the same rd
  assign head_waw = valid_q[head_idx] & data_q[head_idx].rd_upd &
                    data_q[work_idx].rd_upd &
                    (data_q[head_idx].rd_idx == data_q[work_idx].rd_idx);

  // Lookahead slot, only safe and independent work
  assign comm_ooo = valid_q[work_idx] & data_q[work_idx].res_ready &
                    ~data_q[work_idx].order_crit & ~data_q[work_idx].except_raised &
                    (data_q[work_idx].except_code != E_MISPREDICTION) &
                    data_q[work_idx].mem_clear & ~head_waw;

  // Head slot first
  assign commit_valid = comm_in_order | comm_ooo;
  assign commit_idx   = comm_in_order ? head_idx : work_idx;

  // ------------------------------
  // Entry storage
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      head_idx <= '0;
    end else if (flush_i) begin
      valid_q  <= '0;
      head_idx <= '0;
    end else begin
      if (fifo_push) begin
        valid_q[tail_idx] <= 1'b1;
      end
      if (fifo_pop) begin
        valid_q[commit_idx] <= 1'b0;
      end
      // Jump over slots already retired by the lookahead
      if (fifo_pop && comm_in_order) begin
        head_idx <= work_idx;
      end
    end
  end

  // Push overwrites the whole slot, otherwise CDB and clear marks
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (fifo_push && tail_idx == rob_idx_t'(i)) begin
        data_q[i] <= issue_data_i;
      end else begin
        if (cdb.valid && cdb.data.rob_idx == rob_idx_t'(i)) begin
          data_q[i].res_ready     <= 1'b1;
          data_q[i].res_value     <= cdb.data.res_value;
          data_q[i].except_raised <= cdb.data.except_raised;
          data_q[i].except_code   <= cdb.data.except_code;
        end
        if (clear_adv && clear_idx == rob_idx_t'(i)) begin
          data_q[i].mem_clear <= 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // Pointers
  // ------------------------------
  // Next free slot
  modn_counter #(.N(ROB_DEPTH), .INIT(0)) u_tail_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (fifo_push),
    .clr_i  (flush_i),
    .count_o(tail_idx)
  );

  // Oldest entry not yet clear for memory access
  modn_counter #(.N(ROB_DEPTH), .INIT(0)) u_clear_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (clear_adv),
    .clr_i  (flush_i),
    .count_o(clear_idx)
  );

  // Lookahead slot, one past the head after every commit
  modn_counter #(.N(ROB_DEPTH), .INIT(1)) u_work_cnt (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .en_i   (fifo_pop),
    .clr_i  (flush_i),
    .count_o(work_idx)
  );

  // ------------------------------
  // Outputs
  // ------------------------------
  // Entries exist before their results, so always ready
  assign cdb.ready        = 1'b1;
  assign issue_tail_idx_o = tail_idx;

  // Store may go once every older entry is clear
  assign sb_mem_clear_o = valid_q[sb_mem_idx_i] &
                          (data_q[sb_mem_idx_i].mem_clear | (clear_idx == sb_mem_idx_i));

  assign comm.valid = commit_valid;
  assign comm.data  = comm_in_order ? data_q[head_idx] : data_q[work_idx];
  assign comm.idx   = commit_idx;

  assign opfwd.rs1_valid = valid_q[opfwd.rs1_idx];
  assign opfwd.rs1_ready = data_q[opfwd.rs1_idx].res_ready;
  assign opfwd.rs1_value = data_q[opfwd.rs1_idx].res_value;
  assign opfwd.rs2_valid = valid_q[opfwd.rs2_idx];
  assign opfwd.rs2_ready = data_q[opfwd.rs2_idx].res_ready;
  assign opfwd.rs2_value = data_q[opfwd.rs2_idx].res_value;

  // ------------------------------
  // Assertions
  // ------------------------------
  // Accepted issue data sits in the old tail slot next cycle
  a_push_stored: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      fifo_push |=> valid_q[$past(tail_idx)] && data_q[$past(tail_idx)] == $past(issue_data_i)
  );

  // Results only complete allocated entries
  a_cdb_target: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cdb.valid |-> valid_q[cdb.data.rob_idx]
  );

  // Commit offer held while the commit stage stalls
  a_comm_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni || flush_i) comm.valid && !comm.ready |=> comm.valid
  );

  // Any flush source leaves nothing behind
  a_flush_empty: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |=> valid_q == '0
  );

endmodule

// ==== src/reg_status_rf.sv ====
`timescale 1ns/1ps

module reg_status_rf import len5_pkg::*, expipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  // Issue stage
  input  logic                   issue_valid_i,
  input  logic                   issue_ready_i,
  input  logic [REG_IDX_LEN-1:0] issue_rd_i,
  input  logic                   issue_rd_upd_i,
  input  logic [REG_IDX_LEN-1:0] issue_rs1_i,
  input  logic [REG_IDX_LEN-1:0] issue_rs2_i,
  input  rob_idx_t               issue_tail_idx_i,
  // ROB lookup
  opfwd_if.rs                    opfwd,
  // Retirement
  input  logic                   rf_we_i,
  input  logic [REG_IDX_LEN-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]        rf_wdata_i,
  input  rob_idx_t               comm_idx_i,
  // Resolved operands
  output logic                   rs1_ready_o,
  output logic [XLEN-1:0]        rs1_value_o,
  output rob_idx_t               rs1_rob_idx_o,
  output logic                   rs2_ready_o,
  output logic [XLEN-1:0]        rs2_value_o,
  output rob_idx_t               rs2_rob_idx_o
);

  logic [2**REG_IDX_LEN-1:0] busy_q;
  rob_idx_t                  owner_q [2**REG_IDX_LEN];
  logic [XLEN-1:0]           rf_q    [2**REG_IDX_LEN];
  logic                      mark_busy, free_busy;

  // Register zero never tracked
  assign mark_busy = issue_valid_i & issue_ready_i & issue_rd_upd_i & (issue_rd_i != '0);
  // Only the latest writer releases the register
  assign free_busy = rf_we_i & (rf_waddr_i != '0) & (owner_q[rf_waddr_i] == comm_idx_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
    end else if (flush_i) begin
      busy_q <= '0;
    end else begin
      if (free_busy) begin
        busy_q[rf_waddr_i] <= 1'b0;
      end
      // Later assignment, so a new issue to the same rd wins
      if (mark_busy) begin
        busy_q[issue_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mark_busy) begin
      owner_q[issue_rd_i] <= issue_tail_idx_i;
    end
  end

  // Architectural state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < 2**REG_IDX_LEN; r++) begin
        rf_q[r] <= '0;
      end
    end else if (rf_we_i && rf_waddr_i != '0) begin
      rf_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

  // ------------------------------
  // Operand resolution
  // ------------------------------
  assign opfwd.rs1_idx = owner_q[issue_rs1_i];
  assign opfwd.rs2_idx = owner_q[issue_rs2_i];

  // Idle register from the file, busy one from its ROB entry when done
  assign rs1_ready_o   = ~busy_q[issue_rs1_i] | (opfwd.rs1_valid & opfwd.rs1_ready);
  assign rs1_value_o   = busy_q[issue_rs1_i] ? opfwd.rs1_value : rf_q[issue_rs1_i];
  assign rs1_rob_idx_o = owner_q[issue_rs1_i];

  assign rs2_ready_o   = ~busy_q[issue_rs2_i] | (opfwd.rs2_valid & opfwd.rs2_ready);
  assign rs2_value_o   = busy_q[issue_rs2_i] ? opfwd.rs2_value : rf_q[issue_rs2_i];
  assign rs2_rob_idx_o = owner_q[issue_rs2_i];

endmodule

// ==== src/commit_unit.sv ====
`timescale 1ns/1ps

module commit_unit import len5_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  rob_commit_if.cu               comm,
  // Register file write
  output logic                   rf_we_o,
  output logic [REG_IDX_LEN-1:0] rf_waddr_o,
  output logic [XLEN-1:0]        rf_wdata_o,
  // Retirement trace
  output logic                   retire_valid_o,
  output logic [REG_IDX_LEN-1:0] retire_rd_o,
  output logic [XLEN-1:0]        retire_value_o,
  // Exception and pipeline flush
  output logic                   except_o,
  output except_code_t           except_code_o,
  output logic                   flush_o
);

  logic commit;

  // Nothing retires while the flush is in flight
  assign comm.ready = ~flush_o;
  assign commit     = comm.valid & comm.ready;

  // Faulting entry leaves no architectural trace
  assign rf_we_o    = commit & comm.data.rd_upd & ~comm.data.except_raised;
  assign rf_waddr_o = comm.data.rd_idx;
  assign rf_wdata_o = comm.data.res_value;

  assign retire_valid_o = commit & ~comm.data.except_raised;
  assign retire_rd_o    = comm.data.rd_idx;
  assign retire_value_o = comm.data.res_value;

  assign except_o      = commit & comm.data.except_raised;
  assign except_code_o = comm.data.except_code;

  // Flush one cycle after the exception
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_o <= 1'b0;
    end else begin
      flush_o <= except_o;
    end
  end

  // Single-cycle flush pulse
  a_flush_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_o |=> !flush_o
  );

endmodule

// ==== src/expipe_backend.sv ====
`timescale 1ns/1ps

module expipe_backend import len5_pkg::*, expipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  // Issue stage
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  input  logic [REG_IDX_LEN-1:0] issue_rd_i,
  input  logic                   issue_rd_upd_i,
  input  logic [REG_IDX_LEN-1:0] issue_rs1_i,
  input  logic [REG_IDX_LEN-1:0] issue_rs2_i,
  input  logic                   issue_order_crit_i,
  input  logic                   issue_mem_crit_i,
  output rob_idx_t               issue_rob_idx_o,
  // Resolved operands
  output logic                   rs1_ready_o,
  output logic [XLEN-1:0]        rs1_value_o,
  output rob_idx_t               rs1_rob_idx_o,
  output logic                   rs2_ready_o,
  output logic [XLEN-1:0]        rs2_value_o,
  output rob_idx_t               rs2_rob_idx_o,
  // Common data bus
  input  logic                   cdb_valid_i,
  input  rob_idx_t               cdb_rob_idx_i,
  input  logic [XLEN-1:0]        cdb_value_i,
  input  logic                   cdb_except_i,
  input  except_code_t           cdb_except_code_i,
  output logic                   cdb_ready_o,
  // Store buffer
  input  rob_idx_t               sb_mem_idx_i,
  output logic                   sb_mem_clear_o,
  // Retirement
  output logic                   retire_valid_o,
  output logic [REG_IDX_LEN-1:0] retire_rd_o,
  output logic [XLEN-1:0]        retire_value_o,
  output logic                   except_o,
  output except_code_t           except_code_o
);

  cdb_if        cdb ();
  opfwd_if      opfwd ();
  rob_commit_if comm ();

  rob_entry_t             issue_entry;
  logic                   rob_flush, cu_flush;
  logic                   rf_we;
  logic [REG_IDX_LEN-1:0] rf_waddr;
  logic [XLEN-1:0]        rf_wdata;

  // New entry starts with no result, no fault, not clear
  assign issue_entry = '{
    rd_idx:        issue_rd_i,
    rd_upd:        issue_rd_upd_i,
    order_crit:    issue_order_crit_i,
    mem_crit:      issue_mem_crit_i,
    res_ready:     1'b0,
    res_value:     '0,
    except_raised: 1'b0,
    except_code:   E_NONE,
    mem_clear:     1'b0
  };

  assign cdb.valid   = cdb_valid_i;
  assign cdb.data    = '{
    rob_idx:       cdb_rob_idx_i,
    res_value:     cdb_value_i,
    except_raised: cdb_except_i,
    except_code:   cdb_except_code_i
  };
  assign cdb_ready_o = cdb.ready;

  // External flush or committed exception
  assign rob_flush = flush_i | cu_flush;

  rob u_rob (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (rob_flush),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .issue_data_i    (issue_entry),
    .issue_tail_idx_o(issue_rob_idx_o),
    .cdb             (cdb),
    .opfwd           (opfwd),
    .sb_mem_idx_i    (sb_mem_idx_i),
    .sb_mem_clear_o  (sb_mem_clear_o),
    .comm            (comm)
  );

  reg_status_rf u_reg_status_rf (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (rob_flush),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_i   (issue_ready_o),
    .issue_rd_i      (issue_rd_i),
    .issue_rd_upd_i  (issue_rd_upd_i),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs2_i     (issue_rs2_i),
    .issue_tail_idx_i(issue_rob_idx_o),
    .opfwd           (opfwd),
    .rf_we_i         (rf_we),
    .rf_waddr_i      (rf_waddr),
    .rf_wdata_i      (rf_wdata),
    .comm_idx_i      (comm.idx),
    .rs1_ready_o     (rs1_ready_o),
    .rs1_value_o     (rs1_value_o),
    .rs1_rob_idx_o   (rs1_rob_idx_o),
    .rs2_ready_o     (rs2_ready_o),
    .rs2_value_o     (rs2_value_o),
    .rs2_rob_idx_o   (rs2_rob_idx_o)
  );

  commit_unit u_commit_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .comm          (comm),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .retire_valid_o(retire_valid_o),
    .retire_rd_o   (retire_rd_o),
    .retire_value_o(retire_value_o),
    .except_o      (except_o),
    .except_code_o (except_code_o),
    .flush_o       (cu_flush)
  );

endmodule

// ==== tb/tb_expipe_backend.sv ====
`timescale 1ns/1ps

module tb_expipe_backend import len5_pkg::*, expipe_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 40;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   flush_i;
  logic                   issue_valid_i;
  logic                   issue_ready_o;
  logic [REG_IDX_LEN-1:0] issue_rd_i;
  logic                   issue_rd_upd_i;
  logic [REG_IDX_LEN-1:0] issue_rs1_i;
  logic [REG_IDX_LEN-1:0] issue_rs2_i;
  logic                   issue_order_crit_i;
  logic                   issue_mem_crit_i;
  rob_idx_t               issue_rob_idx_o;
  logic                   rs1_ready_o;
  logic [XLEN-1:0]        rs1_value_o;
  rob_idx_t               rs1_rob_idx_o;
  logic                   rs2_ready_o;
  logic [XLEN-1:0]        rs2_value_o;
  rob_idx_t               rs2_rob_idx_o;
  logic                   cdb_valid_i;
  rob_idx_t               cdb_rob_idx_i;
  logic [XLEN-1:0]        cdb_value_i;
  logic                   cdb_except_i;
  except_code_t           cdb_except_code_i;
  logic                   cdb_ready_o;
  rob_idx_t               sb_mem_idx_i;
  logic                   sb_mem_clear_o;
  logic                   retire_valid_o;
  logic [REG_IDX_LEN-1:0] retire_rd_o;
  logic [XLEN-1:0]        retire_value_o;
  logic                   except_o;
  except_code_t           except_code_o;

  // Retirement log filled on each commit edge
  logic [REG_IDX_LEN-1:0] ret_rd_q [$];
  logic [XLEN-1:0]        ret_val_q [$];
  int                     except_cnt;
  except_code_t           except_code_seen;
  integer                 seed;

  expipe_backend expipe_backend_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Commit happens on the edge where these are high
  always @(posedge clk_i) begin
    if (rst_ni && retire_valid_o) begin
      ret_rd_q.push_back(retire_rd_o);
      ret_val_q.push_back(retire_value_o);
    end
    if (rst_ni && except_o) begin
      except_cnt++;
      except_code_seen = except_code_o;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
    end
  endtask

  // Issue one instruction and hand back its tail index
  task automatic drive_issue(input logic [REG_IDX_LEN-1:0] rd, input logic rd_upd,
                             input logic order_crit, input logic mem_crit,
                             output rob_idx_t idx);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_timeout("the ROB to accept an issue");
      end
      cycles++;
      @(negedge clk_i);
    end
    idx                = issue_rob_idx_o;
    issue_valid_i      = 1'b1;
    issue_rd_i         = rd;
    issue_rd_upd_i     = rd_upd;
    issue_order_crit_i = order_crit;
    issue_mem_crit_i   = mem_crit;
    @(negedge clk_i);
    issue_valid_i = 1'b0;
  endtask

  // Single-cycle CDB broadcast
  task automatic send_result(input rob_idx_t idx, input logic [XLEN-1:0] value,
                             input logic exc, input except_code_t code);
    @(negedge clk_i);
    cdb_valid_i       = 1'b1;
    cdb_rob_idx_i     = idx;
    cdb_value_i       = value;
    cdb_except_i      = exc;
    cdb_except_code_i = code;
    @(negedge clk_i);
    cdb_valid_i = 1'b0;
  endtask

  task automatic wait_retired(input int n);
    int cycles;
    cycles = 0;
    while (ret_rd_q.size() < n) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_timeout("instructions to retire");
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic wait_except(input int n);
    int cycles;
    cycles = 0;
    while (except_cnt < n) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_timeout("an exception at commit");
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  task automatic wait_issue_ready();
    int cycles;
    cycles = 0;
    while (!issue_ready_o) begin
      if (cycles == TIMEOUT_CYCLES) begin
        report_timeout("issue_ready_o after the flush");
      end
      cycles++;
      @(negedge clk_i);
    end
  endtask

  // Both source ports look at the same register
  task automatic check_operand(input logic [REG_IDX_LEN-1:0] r, input logic exp_ready,
                               input logic [XLEN-1:0] exp_value, input rob_idx_t exp_idx);
    @(negedge clk_i);
    issue_rs1_i = r;
    issue_rs2_i = r;
    #10;
    check_value("rs1_ready_o", rs1_ready_o, exp_ready);
    check_value("rs2_ready_o", rs2_ready_o, exp_ready);
    if (exp_ready) begin
      check_value("rs1_value_o", rs1_value_o, exp_value);
      check_value("rs2_value_o", rs2_value_o, exp_value);
    end else begin
      check_value("rs1_rob_idx_o", rs1_rob_idx_o, exp_idx);
      check_value("rs2_rob_idx_o", rs2_rob_idx_o, exp_idx);
    end
  endtask

  task automatic check_retired(input int k, input logic [REG_IDX_LEN-1:0] rd,
                               input logic [XLEN-1:0] value);
    check_value("retire_rd_o", ret_rd_q[k], rd);
    check_value("retire_value_o", ret_val_q[k], value);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_state();
    check_value("issue_ready_o", issue_ready_o, 1'b1);
    check_value("retire_valid_o", retire_valid_o, 1'b0);
    check_value("except_o", except_o, 1'b0);
    check_value("sb_mem_clear_o", sb_mem_clear_o, 1'b0);
    // Result bus never stalls
    check_value("cdb_ready_o", cdb_ready_o, 1'b1);
    check_operand(5'd3, 1'b1, '0, '0);
    check_operand(5'd31, 1'b1, '0, '0);
  endtask

  task automatic full_back_pressure();
    rob_idx_t        idx;
    logic [XLEN-1:0] vals [ROB_DEPTH];
    int              base;
    base = ret_rd_q.size();
    for (int i = 0; i < ROB_DEPTH; i++) begin
      drive_issue(REG_IDX_LEN'(i + 1), 1'b1, 1'b1, 1'b0, idx);
      check_value("issue_rob_idx_o", idx, i);
    end
    check_value("issue_ready_o", issue_ready_o, 1'b0);
    // Issue while full leaves the tail and r13 untouched
    issue_rd_i    = 5'd13;
    issue_valid_i = 1'b1;
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    check_value("issue_rob_idx_o", issue_rob_idx_o, 0);
    check_operand(5'd13, 1'b1, '0, '0);
    // Results in slot order, all order-critical so retirement follows
    for (int i = 0; i < ROB_DEPTH; i++) begin
      vals[i] = $random(seed);
      send_result(rob_idx_t'(i), vals[i], 1'b0, E_NONE);
    end
    wait_retired(base + ROB_DEPTH);
    for (int i = 0; i < ROB_DEPTH; i++) begin
      check_retired(base + i, REG_IDX_LEN'(i + 1), vals[i]);
    end
  endtask

  task automatic lookahead_commit();
    rob_idx_t        a_idx;
    rob_idx_t        b_idx;
    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;
    int              base;
    base  = ret_rd_q.size();
    a_val = $random(seed);
    b_val = $random(seed);
    drive_issue(5'd6, 1'b1, 1'b1, 1'b0, a_idx);
    drive_issue(5'd7, 1'b1, 1'b0, 1'b0, b_idx);
    // Younger B overtakes the stalled head
    send_result(b_idx, b_val, 1'b0, E_NONE);
    wait_retired(base + 1);
    check_retired(base, 5'd7, b_val);
    send_result(a_idx, a_val, 1'b0, E_NONE);
    wait_retired(base + 2);
    check_retired(base + 1, 5'd6, a_val);
    check_operand(5'd6, 1'b1, a_val, '0);
    check_operand(5'd7, 1'b1, b_val, '0);
  endtask

  task automatic operand_forwarding();
    rob_idx_t        a_idx;
    rob_idx_t        b_idx;
    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;
    int              base;
    base  = ret_rd_q.size();
    a_val = $random(seed);
    b_val = $random(seed);
    drive_issue(5'd8, 1'b1, 1'b1, 1'b0, a_idx);
    drive_issue(5'd5, 1'b1, 1'b1, 1'b0, b_idx);
    check_operand(5'd5, 1'b0, '0, b_idx);
    send_result(b_idx, b_val, 1'b0, E_NONE);
    // B still waits behind A so its value comes from the ROB entry
    check_operand(5'd5, 1'b1, b_val, '0);
    check_value("retire_valid_o count", ret_rd_q.size(), base);
    send_result(a_idx, a_val, 1'b0, E_NONE);
    wait_retired(base + 2);
    check_retired(base, 5'd8, a_val);
    check_retired(base + 1, 5'd5, b_val);
  endtask

  task automatic store_clear();
    rob_idx_t        m_idx;
    rob_idx_t        s_idx;
    logic [XLEN-1:0] m_val;
    int              base;
    base  = ret_rd_q.size();
    m_val = $random(seed);
    drive_issue(5'd9, 1'b1, 1'b1, 1'b1, m_idx);
    drive_issue(5'd0, 1'b0, 1'b1, 1'b0, s_idx);
    sb_mem_idx_i = s_idx;
    // Older memory-critical entry holds the store back
    repeat (3) begin
      @(negedge clk_i);
      check_value("sb_mem_clear_o", sb_mem_clear_o, 1'b0);
    end
    send_result(m_idx, m_val, 1'b0, E_NONE);
    check_value("sb_mem_clear_o", sb_mem_clear_o, 1'b1);
    send_result(s_idx, '0, 1'b0, E_NONE);
    wait_retired(base + 2);
    check_retired(base, 5'd9, m_val);
    check_retired(base + 1, 5'd0, '0);
    // Store gone from the ROB
    check_value("sb_mem_clear_o", sb_mem_clear_o, 1'b0);
  endtask

  task automatic exception_flush();
    rob_idx_t        h_idx;
    rob_idx_t        y1_idx;
    rob_idx_t        y2_idx;
    logic [XLEN-1:0] h_val;
    logic [XLEN-1:0] y_val;
    int              base;
    int              exc_base;
    base     = ret_rd_q.size();
    exc_base = except_cnt;
    h_val    = $random(seed);
    y_val    = $random(seed);
    drive_issue(5'd10, 1'b1, 1'b1, 1'b1, h_idx);
    drive_issue(5'd11, 1'b1, 1'b0, 1'b0, y1_idx);
    drive_issue(5'd12, 1'b1, 1'b1, 1'b0, y2_idx);
    // Y1 is done but stays behind the faulting head
    send_result(y1_idx, y_val, 1'b0, E_NONE);
    send_result(h_idx, h_val, 1'b1, E_LD_FAULT);
    wait_except(exc_base + 1);
    check_value("except_code_o", except_code_seen, E_LD_FAULT);
    wait_issue_ready();
    check_value("except_o count", except_cnt, exc_base + 1);
    check_value("retire_valid_o count", ret_rd_q.size(), base);
    // Flushed ROB restarts at slot zero
    check_value("issue_rob_idx_o", issue_rob_idx_o, 0);
    check_operand(5'd10, 1'b1, '0, '0);
    check_operand(5'd11, 1'b1, '0, '0);
    check_operand(5'd12, 1'b1, '0, '0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed               = 32'h5ee7;
    except_cnt         = 0;
    rst_ni             = 1'b0;
    flush_i            = 1'b0;
    issue_valid_i      = 1'b0;
    issue_rd_i         = '0;
    issue_rd_upd_i     = 1'b0;
    issue_rs1_i        = '0;
    issue_rs2_i        = '0;
    issue_order_crit_i = 1'b0;
    issue_mem_crit_i   = 1'b0;
    cdb_valid_i        = 1'b0;
    cdb_rob_idx_i      = '0;
    cdb_value_i        = '0;
    cdb_except_i       = 1'b0;
    cdb_except_code_i  = E_NONE;
    sb_mem_idx_i       = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    reset_state();
    full_back_pressure();
    lookahead_commit();
    operand_forwarding();
    store_clear();
    exception_flush();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== expipe_backend.f ====
common/len5_pkg.sv
common/expipe_pkg.sv
common/rob_ifs.sv
src/modn_counter.sv
rob/rob.sv
src/reg_status_rf.sv
src/commit_unit.sv
src/expipe_backend.sv
tb/tb_expipe_backend.sv

// ==== Makefile ====
SRCS := $(wildcard common/*.sv src/*.sv rob/*.sv tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_expipe_backend: expipe_backend.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_expipe_backend -f expipe_backend.f

run: obj_dir/Vtb_expipe_backend
	./obj_dir/Vtb_expipe_backend > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Test failures found" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log
